// ==== filelist.f ====
src/sd_host_pkg.sv
src/sd_clk_generator.sv
src/sd_crc7.sv
src/sd_cmd_tx.sv
src/sd_rsp_rx.sv
src/sd_cmd_host.sv
verification/sd_cmd_host_tb.sv

// ==== src/sd_clk_generator.sv ====
// =====================================================================
// sd clock generator
// divides clk_i down to the sd bus clock and marks its rising and
// falling edges with one-cycle strobes in the clk_i domain
// =====================================================================

`default_nettype none

module sd_clk_generator (
  input  logic       clk_i,
  input  logic       software_reset_cmd_q,
  input  logic       sd_clk_en_i,
  input  logic [7:0] sd_clk_div_i,  // half period is div + 1 cycles
  output logic       sd_clk_o,
  output logic       clk_en_p_o,
  output logic       clk_en_n_o
);

  logic [7:0] half_cnt_q;
  logic       sd_clk_q;
  logic       toggle;

  // >= so that lowering the divider on the fly cannot stall the count
  assign toggle = sd_clk_en_i && (half_cnt_q >= sd_clk_div_i);

  // strobes line up with the clk_i edge that moves sd_clk_o
  assign clk_en_p_o = toggle && !sd_clk_q;  // clock is about to rise
  assign clk_en_n_o = toggle && sd_clk_q;   // clock is about to fall

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      half_cnt_q <= '0;
      sd_clk_q   <= 1'b0;
    end else if (!sd_clk_en_i) begin
      half_cnt_q <= '0;  // park low, restart a full half period later
      sd_clk_q   <= 1'b0;
    end else if (toggle) begin
      half_cnt_q <= '0;
      sd_clk_q   <= !sd_clk_q;
    end else begin
      half_cnt_q <= half_cnt_q + 8'd1;
    end
  end

  assign sd_clk_o = sd_clk_q;

endmodule

`default_nettype wire

// ==== src/sd_cmd_host.sv ====
// =====================================================================
// sd command host
// command line of an sd host controller: clock generation, command
// transmission and response reception, sequenced from a start pulse
// to a single done pulse
// =====================================================================

`default_nettype none

module sd_cmd_host
  import sd_host_pkg::*;
#(
  parameter int RspTimeout = 64
) (
  input  logic         clk_i,
  input  logic         software_reset_cmd_q,
  input  logic         sd_clk_en_i,
  input  logic [7:0]   sd_clk_div_i,
  input  logic         cmd_start_i,
  input  logic [5:0]   cmd_index_i,
  input  logic [31:0]  cmd_arg_i,
  input  rsp_type_e    rsp_type_i,
  input  logic         sd_cmd_i,
  output logic         sd_clk_o,
  output logic         sd_cmd_o,
  output logic         sd_cmd_en_o,
  output logic         cmd_busy_o,
  output logic         cmd_done_o,
  output logic [127:0] rsp_o,
  output err_flags_t   err_o
);

  logic      clk_en_p, clk_en_n;
  logic      tx_start, tx_done;
  logic      rx_arm, rx_done;
  logic      busy_q;
  rsp_type_e rsp_type_q;
  logic [5:0] index_q;  // compared against the echoed index

  assign tx_start   = cmd_start_i && !busy_q;  // starts while busy are dropped
  assign rx_arm     = tx_done && (rsp_type_q != RSP_NONE);
  assign cmd_done_o = (tx_done && (rsp_type_q == RSP_NONE)) || rx_done;

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      busy_q <= 1'b0;
    end else if (tx_start) begin
      busy_q     <= 1'b1;
      rsp_type_q <= rsp_type_i;
      index_q    <= cmd_index_i;
    end else if (cmd_done_o) begin
      busy_q <= 1'b0;
    end
  end

  assign cmd_busy_o = busy_q;

  sd_clk_generator i_sd_clk_generator (
    .clk_i,
    .software_reset_cmd_q,
    .sd_clk_en_i,
    .sd_clk_div_i,
    .sd_clk_o,
    .clk_en_p_o (clk_en_p),
    .clk_en_n_o (clk_en_n)
  );

  sd_cmd_tx i_sd_cmd_tx (
    .clk_i,
    .software_reset_cmd_q,
    .clk_en_n_i  (clk_en_n),
    .start_i     (tx_start),
    .cmd_index_i,
    .cmd_arg_i,
    .sd_cmd_o,
    .sd_cmd_en_o,
    .done_o      (tx_done)
  );

  sd_rsp_rx #(
    .RspTimeout (RspTimeout)
  ) i_sd_rsp_rx (
    .clk_i,
    .software_reset_cmd_q,
    .clk_en_p_i  (clk_en_p),
    .arm_i       (rx_arm),
    .rsp_type_i  (rsp_type_q),
    .cmd_index_i (index_q),
    .sd_cmd_i,
    .done_o      (rx_done),
    .rsp_o,
    .err_o
  );

endmodule

`default_nettype wire

// ==== src/sd_cmd_tx.sv ====
// =====================================================================
// sd command transmitter
// shifts a 48-bit command frame onto the CMD line on falling sd clock
// edges, appends the crc7 and end bit, then releases the line
// =====================================================================

`default_nettype none

module sd_cmd_tx
  import sd_host_pkg::*;
(
  input  logic        clk_i,
  input  logic        software_reset_cmd_q,
  input  logic        clk_en_n_i,
  input  logic        start_i,
  input  logic [5:0]  cmd_index_i,
  input  logic [31:0] cmd_arg_i,
  output logic        sd_cmd_o,
  output logic        sd_cmd_en_o,
  output logic        done_o
);

  localparam int CrcStart = CMD_FRAME_LEN - 8;  // first crc bit position
  localparam int EndPos   = CMD_FRAME_LEN - 1;

  logic [39:0] frame_q;  // start, transmission, index, argument
  logic [5:0]  bit_cnt_q;
  logic        active_q;
  logic        cmd_q;
  logic        cmd_en_q;
  logic        done_q;
  logic        load;
  logic        crc_shift;
  logic [2:0]  crc_sel;
  logic [6:0]  crc;

  assign load      = start_i && !active_q;
  assign crc_shift = active_q && clk_en_n_i && (bit_cnt_q < 6'(CrcStart));
  assign crc_sel   = 3'(6'(CMD_FRAME_LEN - 2) - bit_cnt_q);  // 6 down to 0

  sd_crc7 i_crc7 (
    .clk_i,
    .software_reset_cmd_q,
    .clear_i (load),
    .shift_i (crc_shift),
    .bit_i   (frame_q[39]),
    .crc_o   (crc)
  );

  always_ff @(posedge clk_i) begin
    done_q <= 1'b0;
    if (software_reset_cmd_q) begin
      active_q  <= 1'b0;
      bit_cnt_q <= '0;
      cmd_q     <= 1'b1;  // idle level
      cmd_en_q  <= 1'b0;
    end else if (load) begin
      active_q  <= 1'b1;
      bit_cnt_q <= '0;
      frame_q   <= {1'b0, 1'b1, cmd_index_i, cmd_arg_i};
    end else if (active_q && clk_en_n_i) begin
      bit_cnt_q <= bit_cnt_q + 6'd1;
      if (bit_cnt_q < 6'(CrcStart)) begin
        cmd_q    <= frame_q[39];
        cmd_en_q <= 1'b1;
        frame_q  <= {frame_q[38:0], 1'b0};
      end else if (bit_cnt_q < 6'(EndPos)) begin
        cmd_q <= crc[crc_sel];  // msb first
      end else if (bit_cnt_q == 6'(EndPos)) begin
        cmd_q <= 1'b1;  // end bit
      end else begin
        // end bit has been on the line for a full period
        cmd_en_q <= 1'b0;
        active_q <= 1'b0;
        done_q   <= 1'b1;
      end
    end
  end

  assign sd_cmd_o    = cmd_q;
  assign sd_cmd_en_o = cmd_en_q;
  assign done_o      = done_q;

endmodule

`default_nettype wire

// ==== src/sd_crc7.sv ====
// =====================================================================
// serial crc7
// bitwise crc7 accumulator for command and response frames
// =====================================================================

`default_nettype none

module sd_crc7
  import sd_host_pkg::*;
(
  input  logic       clk_i,
  input  logic       software_reset_cmd_q,
  input  logic       clear_i,  // start of a new frame
  input  logic       shift_i,  // one frame bit per strobe
  input  logic       bit_i,
  output logic [6:0] crc_o
);

  logic [6:0] crc_q;
  logic       feedback;

  assign feedback = bit_i ^ crc_q[6];

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q || clear_i) begin
      crc_q <= '0;
    end else if (shift_i) begin
      crc_q <= {crc_q[5:0], 1'b0} ^ (feedback ? CRC7_POLY : 7'h00);
    end
  end

  assign crc_o = crc_q;

endmodule

`default_nettype wire

// ==== src/sd_host_pkg.sv ====
// =====================================================================
// sd host command path definitions
// response type encoding, frame lengths, error flags and the CRC7
// generator shared by the transmitter, receiver and top level
// =====================================================================

`default_nettype none

package sd_host_pkg;

  // what the receiver expects after a command
  typedef enum logic [1:0] {
    RSP_NONE  = 2'd0,
    RSP_SHORT = 2'd1,  // R1, R3, R6, R7
    RSP_LONG  = 2'd2   // R2 (CID / CSD)
  } rsp_type_e;

  // frame lengths on the CMD line, start and end bit included
  localparam int CMD_FRAME_LEN = 48;
  localparam int RSP_SHORT_LEN = 48;
  localparam int RSP_LONG_LEN  = 136;

  // response error flags, msb first
  typedef struct packed {
    logic timeout;  // no start bit within the timeout window
    logic crc;      // crc7 mismatch, short responses only
    logic end_bit;  // end bit was 0
    logic index;    // echoed index differs from the command
  } err_flags_t;

  // x^7 + x^3 + 1 with the x^7 term dropped
  localparam logic [6:0] CRC7_POLY = 7'h09;

endpackage

`default_nettype wire

// ==== src/sd_rsp_rx.sv ====
// =====================================================================
// sd response receiver
// waits for the card's start bit, shifts in a short or long response
// on rising sd clock edges and reports timeout, crc, end bit and
// index errors
// =====================================================================

`default_nettype none

module sd_rsp_rx
  import sd_host_pkg::*;
#(
  parameter int RspTimeout = 64  // rising edges to wait for a start bit
) (
  input  logic         clk_i,
  input  logic         software_reset_cmd_q,
  input  logic         clk_en_p_i,
  input  logic         arm_i,
  input  rsp_type_e    rsp_type_i,
  input  logic [5:0]   cmd_index_i,
  input  logic         sd_cmd_i,
  output logic         done_o,
  output logic [127:0] rsp_o,
  output err_flags_t   err_o
);

  localparam int TmoW = $clog2(RspTimeout + 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WAIT,
    RX_RECV
  } rx_state_e;

  rx_state_e      state_q;
  logic [TmoW-1:0] tmo_cnt_q;
  logic [7:0]     bit_cnt_q;  // position of the bit being sampled
  logic [126:0]   shift_q;
  logic [127:0]   rsp_q;
  rsp_type_e      type_q;
  logic [5:0]     index_q;
  err_flags_t     err_q;
  logic           done_q;
  logic [7:0]     last_bit;
  logic           crc_shift;
  logic [6:0]     crc;

  assign last_bit = (type_q == RSP_LONG) ? 8'(RSP_LONG_LEN - 1) : 8'(RSP_SHORT_LEN - 1);

  // start bit leaves a cleared crc at zero, so bits 1..39 are enough
  assign crc_shift = (state_q == RX_RECV) && clk_en_p_i && (type_q == RSP_SHORT)
                     && (bit_cnt_q <= 8'(RSP_SHORT_LEN - 9));

  sd_crc7 i_crc7 (
    .clk_i,
    .software_reset_cmd_q,
    .clear_i (arm_i),
    .shift_i (crc_shift),
    .bit_i   (sd_cmd_i),
    .crc_o   (crc)
  );

  always_ff @(posedge clk_i) begin
    done_q <= 1'b0;
    if (software_reset_cmd_q) begin
      state_q   <= RX_IDLE;
      tmo_cnt_q <= '0;
      bit_cnt_q <= '0;
      err_q     <= '0;
    end else begin
      case (state_q)
        RX_IDLE: begin
          if (arm_i) begin
            state_q   <= RX_WAIT;
            tmo_cnt_q <= '0;
            type_q    <= rsp_type_i;
            index_q   <= cmd_index_i;
          end
        end
        RX_WAIT: begin
          if (clk_en_p_i) begin
            if (!sd_cmd_i) begin
              state_q   <= RX_RECV;  // start bit
              bit_cnt_q <= 8'd1;
            end else if (tmo_cnt_q == TmoW'(RspTimeout - 1)) begin
              state_q <= RX_IDLE;
              done_q  <= 1'b1;
              rsp_q   <= '0;
              err_q   <= '{timeout: 1'b1, default: 1'b0};
            end else begin
              tmo_cnt_q <= tmo_cnt_q + 1'b1;
            end
          end
        end
        RX_RECV: begin
          if (clk_en_p_i) begin
            bit_cnt_q <= bit_cnt_q + 8'd1;
            shift_q   <= {shift_q[125:0], sd_cmd_i};
            if (bit_cnt_q == last_bit) begin
              // shift_q holds frame bits N-2..1, sd_cmd_i is the end bit
              state_q       <= RX_IDLE;
              done_q        <= 1'b1;
              err_q.timeout <= 1'b0;
              err_q.end_bit <= !sd_cmd_i;
              if (type_q == RSP_LONG) begin
                rsp_q       <= {shift_q, 1'b0};  // payload 127..1
                err_q.crc   <= 1'b0;
                err_q.index <= 1'b0;
              end else begin
                rsp_q       <= {96'd0, shift_q[38:7]};  // argument field
                err_q.crc   <= (shift_q[6:0] != crc);
                err_q.index <= (shift_q[44:39] != index_q);
              end
            end
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  assign done_o = done_q;
  assign rsp_o  = rsp_q;
  assign err_o  = err_q;

endmodule

`default_nettype wire

// ==== verification/sd_cmd_host_tb.sv ====
// =====================================================================
// sd command host testbench
// card model on the CMD line, reference frame and crc7, random and
// directed commands, a done checker and a watchdog
// =====================================================================

`default_nettype none

module sd_cmd_host_tb
  import sd_host_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int rsp_timeout = 64;
  localparam int clk_period  = 8;
  localparam int max_div     = 3;
  // 20 commands of frame, long response and timeout at the slowest clock, doubled
  localparam int watchdog_ns = 2 * 20 * (CMD_FRAME_LEN + RSP_LONG_LEN + rsp_timeout)
                               * 2 * (max_div + 1) * clk_period;

  // how the card answers a command
  localparam int mode_ok      = 0;
  localparam int mode_bad_crc = 1;
  localparam int mode_bad_idx = 2;
  localparam int mode_long    = 3;
  localparam int mode_silent  = 4;

  logic         clk_i;
  logic         software_reset_cmd_q;
  logic         sd_clk_en_i;
  logic [7:0]   sd_clk_div_i;
  logic         cmd_start_i;
  logic [5:0]   cmd_index_i;
  logic [31:0]  cmd_arg_i;
  rsp_type_e    rsp_type_i;
  logic         sd_cmd_i;
  logic         sd_clk_o;
  logic         sd_cmd_o;
  logic         sd_cmd_en_o;
  logic         cmd_busy_o;
  logic         cmd_done_o;
  logic [127:0] rsp_o;
  err_flags_t   err_o;

  integer       seed = 32'h090a_f98b;
  int           card_mode = mode_silent;
  logic [31:0]  card_arg;
  logic [127:0] card_payload;
  logic [47:0]  cap_frame;   // last frame seen by the card
  int           cap_count = 0;
  int           done_count = 0;
  logic [47:0]  exp_frame;
  logic [127:0] exp_rsp;
  err_flags_t   exp_err;

  sd_cmd_host #(
    .RspTimeout (rsp_timeout)
  ) DUT (
    .clk_i,
    .software_reset_cmd_q,
    .sd_clk_en_i,
    .sd_clk_div_i,
    .cmd_start_i,
    .cmd_index_i,
    .cmd_arg_i,
    .rsp_type_i,
    .sd_cmd_i,
    .sd_clk_o,
    .sd_cmd_o,
    .sd_cmd_en_o,
    .cmd_busy_o,
    .cmd_done_o,
    .rsp_o,
    .err_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // remainder of M(x) * x^7 divided by x^7 + x^3 + 1
  function automatic logic [6:0] crc7_ref(input logic [39:0] data);
    logic [46:0] rem;
    rem = {data, 7'd0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) begin
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
    end
    return rem[6:0];
  endfunction

  // tx_bit is 1 for host commands and 0 for card responses
  function automatic logic [47:0] frame_ref(input logic tx_bit, input logic [5:0] idx,
                                            input logic [31:0] arg);
    logic [39:0] head;
    head = {1'b0, tx_bit, idx, arg};
    return {head, crc7_ref(head), 1'b1};
  endfunction

  task automatic fail_now(input string msg);
    $display("error: t=%0t %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic wait_sd_periods(input int n);
    repeat (n * 2 * (int'(sd_clk_div_i) + 1)) @(posedge clk_i);
  endtask

  task automatic set_divider(input logic [7:0] div);
    @(posedge clk_i);
    #1;
    sd_clk_div_i = div;
  endtask

  task automatic run_cmd(input rsp_type_e rtype, input int mode);
    logic [31:0] rnd;
    logic [5:0]  idx;
    logic [31:0] arg;
    int          target;
    rnd          = $random(seed);
    idx          = rnd[5:0];
    arg          = $random(seed);
    card_arg     = $random(seed);
    card_payload = {$random(seed), $random(seed), $random(seed), $random(seed)};
    card_mode    = mode;
    target       = done_count + 1;
    exp_frame    = frame_ref(1'b1, idx, arg);
    if (rtype != RSP_NONE) begin  // with no response the old result stays
      exp_rsp = {96'd0, card_arg};
      exp_err = '0;
      case (mode)
        mode_bad_crc: exp_err.crc = 1'b1;
        mode_bad_idx: exp_err.index = 1'b1;
        mode_long:    exp_rsp = {card_payload[127:1], 1'b0};
        mode_silent: begin
          exp_rsp         = '0;
          exp_err.timeout = 1'b1;
        end
        default: ;
      endcase
    end
    @(posedge clk_i);
    #1;
    cmd_index_i = idx;
    cmd_arg_i   = arg;
    rsp_type_i  = rtype;
    cmd_start_i = 1'b1;
    @(posedge clk_i);
    #1;
    cmd_start_i = 1'b0;
    assert (cmd_busy_o) else fail_now("cmd_busy_o did not rise after an accepted start");
    // a second start while busy must be dropped
    @(posedge clk_i);
    #1;
    cmd_index_i = ~idx;
    rsp_type_i  = (rtype == RSP_NONE) ? RSP_SHORT : RSP_NONE;
    cmd_start_i = 1'b1;
    @(posedge clk_i);
    #1;
    cmd_start_i = 1'b0;
    wait (done_count == target);
    if (rtype == RSP_NONE) begin
      wait_sd_periods(rsp_timeout + 8);  // long enough for a stray receiver timeout
    end else begin
      wait_sd_periods(4);
    end
    assert (done_count == target)
      else fail_now($sformatf("cmd_done_o pulsed %0d times, expected 1",
                              done_count - target + 1));
    assert (!cmd_busy_o) else fail_now("cmd_busy_o still high after cmd_done_o");
  endtask

  // soft reset while the frame is on the line
  task automatic reset_mid_frame();
    card_mode = mode_ok;
    @(posedge clk_i);
    #1;
    cmd_index_i = 6'd17;
    cmd_arg_i   = $random(seed);
    rsp_type_i  = RSP_SHORT;
    cmd_start_i = 1'b1;
    @(posedge clk_i);
    #1;
    cmd_start_i = 1'b0;
    repeat (12) @(posedge sd_clk_o);
    #1;
    assert (sd_cmd_en_o) else fail_now("CMD line not driven in the middle of a frame");
    software_reset_cmd_q = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    assert (!sd_cmd_en_o && sd_cmd_o)
      else fail_now($sformatf("CMD line en=%b val=%b after soft reset, expected 0 and 1",
                              sd_cmd_en_o, sd_cmd_o));
    assert (!cmd_busy_o && err_o == '0 && !sd_clk_o)
      else fail_now("busy, error flags or sd clock not cleared by soft reset");
    software_reset_cmd_q = 1'b0;
    wait_sd_periods(4);
  endtask

  // with the enable low the sd clock parks low
  task automatic check_clock_gate();
    @(posedge clk_i);
    #1;
    sd_clk_en_i = 1'b0;
    @(posedge clk_i);
    repeat (4 * (int'(sd_clk_div_i) + 1)) begin
      @(posedge clk_i);
      #1;
      assert (!sd_clk_o) else fail_now("sd_clk_o toggled while sd_clk_en_i was low");
    end
    sd_clk_en_i = 1'b1;
  endtask

  // card: collect the frame on rising sd_clk, answer on falling sd_clk
  initial begin : card_model
    logic [47:0]  rx_frame;
    logic [135:0] tx_bits;
    int           nbits;
    int           tx_len;
    sd_cmd_i = 1'b1;  // pulled up when nobody drives
    nbits    = 0;
    forever begin
      @(posedge sd_clk_o);
      if (sd_cmd_en_o) begin
        rx_frame = {rx_frame[46:0], sd_cmd_o};
        nbits++;
      end else begin
        nbits = 0;  // frame cut short by reset
      end
      if (nbits == CMD_FRAME_LEN) begin
        nbits     = 0;
        cap_frame = rx_frame;
        cap_count++;
        tx_len  = RSP_SHORT_LEN;
        tx_bits = {88'd0, frame_ref(1'b0, rx_frame[45:40], card_arg)};
        case (card_mode)
          mode_bad_crc: tx_bits[1] = !tx_bits[1];
          mode_bad_idx: tx_bits = {88'd0, frame_ref(1'b0, rx_frame[45:40] ^ 6'h01, card_arg)};
          mode_long: begin
            tx_len  = RSP_LONG_LEN;
            tx_bits = {2'b00, 6'h3f, card_payload[127:1], 1'b1};
          end
          default: ;
        endcase
        if (card_mode != mode_silent) begin
          repeat (3) @(negedge sd_clk_o);  // NCR gap
          for (int i = tx_len - 1; i >= 0; i--) begin
            #1 sd_cmd_i = tx_bits[i];
            @(negedge sd_clk_o);
          end
          #1 sd_cmd_i = 1'b1;
        end
      end
    end
  end

  // compare results on every done pulse
  initial begin : done_check
    forever begin
      @(negedge clk_i);
      if (cmd_done_o) begin
        done_count++;
        assert (cap_count == done_count)
          else fail_now("command finished but the card saw no complete frame");
        assert (cap_frame == exp_frame)
          else fail_now($sformatf("frame %012h, expected %012h", cap_frame, exp_frame));
        assert (err_o == exp_err)
          else fail_now($sformatf("err_o %04b, expected %04b", err_o, exp_err));
        assert (rsp_o == exp_rsp)
          else fail_now($sformatf("rsp_o %032h, expected %032h", rsp_o, exp_rsp));
      end
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("error: t=%0t test hung, commands did not finish in time", $time);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    software_reset_cmd_q = 1'b1;
    sd_clk_en_i          = 1'b1;
    sd_clk_div_i         = 8'd1;
    cmd_start_i          = 1'b0;
    cmd_index_i          = '0;
    cmd_arg_i            = '0;
    rsp_type_i           = RSP_NONE;
    repeat (5) @(posedge clk_i);
    #1;
    assert (!sd_cmd_en_o && sd_cmd_o && !cmd_busy_o && !cmd_done_o && !sd_clk_o
            && err_o == '0)
      else fail_now("outputs not idle during reset");
    software_reset_cmd_q = 1'b0;
    repeat (6) begin
      run_cmd(RSP_SHORT, mode_ok);
    end
    run_cmd(RSP_SHORT, mode_bad_crc);
    run_cmd(RSP_SHORT, mode_bad_idx);
    run_cmd(RSP_SHORT, mode_silent);
    run_cmd(RSP_LONG, mode_long);
    run_cmd(RSP_LONG, mode_long);
    run_cmd(RSP_NONE, mode_silent);
    reset_mid_frame();
    set_divider(8'd0);  // fastest sd clock
    run_cmd(RSP_SHORT, mode_ok);
    run_cmd(RSP_LONG, mode_long);
    set_divider(8'd3);
    run_cmd(RSP_SHORT, mode_ok);
    run_cmd(RSP_SHORT, mode_silent);
    check_clock_gate();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
